// File: src/bp_pkg.sv
// Shared types for the branch prediction unit.
// Tag fields are sized for the smallest table (INDEX_BITS = 1). Larger tables
// keep the unused upper tag bits at zero.
// Instructions are halfword aligned, so PC bit 0 never takes part in indexing.

`default_nettype none

package bp_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////
  localparam int PC_WIDTH  = 16;            // Instruction address width
  localparam int TAG_WIDTH = PC_WIDTH - 2;  // Widest tag, bit 0 plus one index bit dropped

  typedef logic [PC_WIDTH-1:0]  pc_t;       // Instruction address
  typedef logic [TAG_WIDTH-1:0] tag_t;      // Zero-extended PC tag

  localparam pc_t PC_STEP = 16'd2;          // Fall-through distance, one halfword

  ////////////////////////////////////////////////////////////
  // Counter states
  ////////////////////////////////////////////////////////////
  // Upper bit is the predicted direction
  typedef enum logic [1:0] {
    strong_nt = 2'd0,
    weak_nt   = 2'd1,
    weak_t    = 2'd2,
    strong_t  = 2'd3
  } ctr_state_e;

  ////////////////////////////////////////////////////////////
  // Table entries
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic       valid;  // Entry written since reset
    tag_t       tag;    // PC bits above the index
    ctr_state_e state;  // 2-bit saturating counter
  } bht_entry_t;

  typedef struct packed {
    logic valid;   // Entry written since reset
    tag_t tag;     // PC bits above the index
    pc_t  target;  // Last taken target seen for this branch
  } btb_entry_t;

endpackage

`default_nettype wire

// File: src/bp_if.sv
// Lookup and update buses between the top level, the two tables and the
// resolve logic. Index and tag are derived here once, so both tables agree.
// INDEX_BITS must match the tables attached to the bus (1 to 8).

`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////
// Fetch side lookup bus
////////////////////////////////////////////////////////////
interface bp_lookup_if #(
  parameter int INDEX_BITS = 3
);

  logic                    lookup_en;  // Fetch is presenting a PC
  bp_pkg::pc_t             fetch_pc;   // Current fetch PC
  logic [INDEX_BITS-1:0]   fetch_idx;  // Table index of fetch_pc
  bp_pkg::tag_t            fetch_tag;  // Tag of fetch_pc
  logic                    ctr_hit;    // History table hit (bht)
  bp_pkg::ctr_state_e      ctr_state;  // Counter state, strong_nt on miss (bht)
  logic                    tgt_hit;    // Target buffer hit (btb)
  bp_pkg::pc_t             tgt;        // Stored target (btb)

  assign fetch_idx = fetch_pc[INDEX_BITS:1];                          // Skip bit 0
  assign fetch_tag = bp_pkg::tag_t'(fetch_pc >> (INDEX_BITS + 1));   // Upper bits

  // Each table drives only its own pair of results
  modport tbl  (input lookup_en, fetch_idx, fetch_tag,
                output ctr_hit, ctr_state, tgt_hit, tgt);
  modport user (output lookup_en, fetch_pc,
                input ctr_hit, ctr_state, tgt_hit, tgt);

endinterface

////////////////////////////////////////////////////////////
// Decode side update bus
////////////////////////////////////////////////////////////
interface bp_update_if #(
  parameter int INDEX_BITS = 3
);

  bp_pkg::pc_t           pc;          // Resolved branch PC
  logic [INDEX_BITS-1:0] upd_idx;     // Table index of pc
  bp_pkg::tag_t          upd_tag;     // Tag of pc
  logic                  bht_wen;     // Write the history entry
  logic                  btb_wen;     // Write the target entry
  bp_pkg::ctr_state_e    new_state;   // Counter value to store
  bp_pkg::pc_t           new_target;  // Target to store
  logic                  upd_hit;     // Target buffer probe hit for pc
  bp_pkg::pc_t           upd_target;  // Target currently stored for pc

  assign upd_idx = pc[INDEX_BITS:1];
  assign upd_tag = bp_pkg::tag_t'(pc >> (INDEX_BITS + 1));

  modport ctrl (output pc, bht_wen, btb_wen, new_state, new_target,
                input upd_hit, upd_target);
  modport tbl  (input upd_idx, upd_tag, bht_wen, btb_wen, new_state, new_target,
                output upd_hit, upd_target);

endinterface

`default_nettype wire

// File: src/bht.sv
// Branch history table, direct mapped, 2**INDEX_BITS tagged 2-bit counters.
// Read is combinational and a write lands on the next rising edge.
// There is no bypass, so a lookup in the write cycle returns the old entry.

`timescale 1ns/100ps
`default_nettype none

module bht #(
  parameter int INDEX_BITS = 3
) (
  input  wire             clk,
  input  wire             rst,
  bp_lookup_if.tbl        lookup,  // Fetch lookup bus driving ctr_hit and ctr_state
  bp_update_if.tbl        upd      // Update from the resolve logic
);

  localparam int ENTRIES = 1 << INDEX_BITS;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////
  bp_pkg::bht_entry_t mem [ENTRIES];  // Counter array

  bp_pkg::bht_entry_t rd_entry;       // Entry selected by fetch_pc
  logic               tag_match;      // Stored tag equals fetch tag

  ////////////////////////////////////////////////////////////
  // Lookup path
  ////////////////////////////////////////////////////////////
  assign rd_entry  = mem[lookup.fetch_idx];
  assign tag_match = (rd_entry.tag == lookup.fetch_tag);

  always_comb begin
    lookup.ctr_hit   = 1'b0;
    lookup.ctr_state = bp_pkg::strong_nt;  // Miss reads as strongly not taken
    if (lookup.lookup_en && rd_entry.valid && tag_match) begin
      lookup.ctr_hit   = 1'b1;
      lookup.ctr_state = rd_entry.state;
    end
  end

  ////////////////////////////////////////////////////////////
  // Update path
  ////////////////////////////////////////////////////////////
  // Reset clears the valid bits only
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ENTRIES; i++) begin
        mem[i].valid <= 1'b0;
      end
    end else if (upd.bht_wen) begin
      // Every resolve overwrites, so an alias evicts the old branch
      mem[upd.upd_idx].valid <= 1'b1;
      mem[upd.upd_idx].tag   <= upd.upd_tag;
      mem[upd.upd_idx].state <= upd.new_state;
    end
  end

endmodule

`default_nettype wire

// File: src/btb.sv
// Branch target buffer, direct mapped, 2**INDEX_BITS tagged targets.
// Two combinational read ports: fetch lookup, and a probe at the resolved PC
// that tells the resolve logic whether the stored target is stale.
// Writes land on the next rising edge, no same-cycle bypass.

`timescale 1ns/100ps
`default_nettype none

module btb #(
  parameter int INDEX_BITS = 3
) (
  input  wire      clk,
  input  wire      rst,
  bp_lookup_if.tbl lookup,  // Fetch lookup, drives tgt_hit and tgt
  bp_update_if.tbl upd      // Update bus, drives the probe results
);

  localparam int ENTRIES = 1 << INDEX_BITS;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////
  bp_pkg::btb_entry_t mem [ENTRIES];

  bp_pkg::btb_entry_t fetch_entry;  // Entry at the fetch index
  bp_pkg::btb_entry_t probe_entry;  // Entry at the resolved index

  ////////////////////////////////////////////////////////////
  // Fetch lookup
  ////////////////////////////////////////////////////////////
  assign fetch_entry = mem[lookup.fetch_idx];

  assign lookup.tgt_hit = lookup.lookup_en && fetch_entry.valid
                          && (fetch_entry.tag == lookup.fetch_tag);
  assign lookup.tgt     = fetch_entry.target;  // Only meaningful with tgt_hit

  ////////////////////////////////////////////////////////////
  // Resolve probe
  ////////////////////////////////////////////////////////////
  assign probe_entry = mem[upd.upd_idx];

  // Not gated by a resolve strobe, the resolve logic qualifies it
  assign upd.upd_hit    = probe_entry.valid && (probe_entry.tag == upd.upd_tag);
  assign upd.upd_target = probe_entry.target;

  ////////////////////////////////////////////////////////////
  // Update
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ENTRIES; i++) begin
        mem[i].valid <= 1'b0;  // Targets left as they are
      end
    end else if (upd.btb_wen) begin
      mem[upd.upd_idx].valid  <= 1'b1;
      mem[upd.upd_idx].tag    <= upd.upd_tag;
      mem[upd.upd_idx].target <= upd.new_target;
    end
  end

endmodule

`default_nettype wire

// File: src/bp_resolve.sv
// Resolve logic, purely combinational.
// Computes the next counter state, the table write enables and mispredict
// from what decode sends back. The predicted state and target are the ones
// fetch saw, so the tables are not read for the direction check.

`timescale 1ns/100ps
`default_nettype none

module bp_resolve (
  input  wire                      resolve_valid,        // One resolved branch this cycle
  input  bp_pkg::pc_t              resolve_pc,           // PC of the branch
  input  bp_pkg::ctr_state_e       resolve_pred_state,   // Counter state used at fetch
  input  bp_pkg::pc_t              resolve_pred_target,  // Target predicted at fetch
  input  wire                      resolve_taken,        // Actual direction
  input  bp_pkg::pc_t              resolve_target,       // Actual target
  bp_update_if.ctrl                upd,                  // Table update bus
  output logic                     mispredict            // Valid only with resolve_valid
);

  logic pred_dir;       // Direction predicted at fetch
  logic dir_wrong;      // Predicted direction differs from outcome
  logic target_wrong;   // Taken and predicted taken, but target differs
  logic target_stale;   // Buffer misses or holds another target

  ////////////////////////////////////////////////////////////
  // Saturating counter
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (resolve_pred_state)
      bp_pkg::strong_nt: upd.new_state = resolve_taken ? bp_pkg::weak_nt  : bp_pkg::strong_nt;
      bp_pkg::weak_nt:   upd.new_state = resolve_taken ? bp_pkg::weak_t   : bp_pkg::strong_nt;
      bp_pkg::weak_t:    upd.new_state = resolve_taken ? bp_pkg::strong_t : bp_pkg::weak_nt;
      bp_pkg::strong_t:  upd.new_state = resolve_taken ? bp_pkg::strong_t : bp_pkg::weak_t;
      default:           upd.new_state = bp_pkg::strong_nt;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Table writes
  ////////////////////////////////////////////////////////////
  assign upd.pc         = resolve_pc;
  assign upd.new_target = resolve_target;
  assign upd.bht_wen    = resolve_valid;  // History updated on every resolve

  // Probe results come back from the btb on the same bus
  assign target_stale = !upd.upd_hit || (upd.upd_target != resolve_target);
  assign upd.btb_wen  = resolve_valid && resolve_taken && target_stale;

  ////////////////////////////////////////////////////////////
  // Misprediction
  ////////////////////////////////////////////////////////////
  assign pred_dir     = resolve_pred_state[1];  // Upper bit is the direction
  assign dir_wrong    = (pred_dir != resolve_taken);
  assign target_wrong = resolve_taken && pred_dir
                        && (resolve_pred_target != resolve_target);

  assign mispredict = resolve_valid && (dir_wrong || target_wrong);

endmodule

`default_nettype wire

// File: src/branch_predictor.sv
// Branch prediction unit top level: history table, target buffer and resolve.
// Lookup is combinational from fetch_pc. An update in the resolve cycle is
// visible to lookups from the following cycle.
// INDEX_BITS from 1 to 8, table size 2**INDEX_BITS.

`timescale 1ns/100ps
`default_nettype none

module branch_predictor #(
  parameter int INDEX_BITS = 3  // 8 entries per table
) (
  input  wire                clk,
  input  wire                rst,
  // Fetch side
  input  wire                lookup_en,
  input  bp_pkg::pc_t        fetch_pc,
  output logic               pred_taken,
  output bp_pkg::ctr_state_e pred_state,   // Sent down the pipe with the branch
  output bp_pkg::pc_t        pred_target,
  // Decode side
  input  wire                resolve_valid,
  input  bp_pkg::pc_t        resolve_pc,
  input  bp_pkg::ctr_state_e resolve_pred_state,
  input  bp_pkg::pc_t        resolve_pred_target,
  input  wire                resolve_taken,
  input  bp_pkg::pc_t        resolve_target,
  output logic               mispredict
);

  bp_lookup_if #(.INDEX_BITS(INDEX_BITS)) look_if ();
  bp_update_if #(.INDEX_BITS(INDEX_BITS)) upd_if ();

  ////////////////////////////////////////////////////////////
  // Lookup path
  ////////////////////////////////////////////////////////////
  assign look_if.lookup_en = lookup_en;
  assign look_if.fetch_pc  = fetch_pc;

  bht #(.INDEX_BITS(INDEX_BITS)) bht_i (
    .clk    (clk),
    .rst    (rst),
    .lookup (look_if.tbl),
    .upd    (upd_if.tbl)
  );

  btb #(.INDEX_BITS(INDEX_BITS)) btb_i (
    .clk    (clk),
    .rst    (rst),
    .lookup (look_if.tbl),
    .upd    (upd_if.tbl)
  );

  // Both tables already report a miss with lookup_en low
  assign pred_taken  = look_if.ctr_hit && look_if.ctr_state[1];
  assign pred_state  = look_if.ctr_state;
  assign pred_target = look_if.tgt_hit ? look_if.tgt
                                       : fetch_pc + bp_pkg::PC_STEP;  // Fall through

  ////////////////////////////////////////////////////////////
  // Update path
  ////////////////////////////////////////////////////////////
  bp_resolve resolve_i (
    .resolve_valid       (resolve_valid),
    .resolve_pc          (resolve_pc),
    .resolve_pred_state  (resolve_pred_state),
    .resolve_pred_target (resolve_pred_target),
    .resolve_taken       (resolve_taken),
    .resolve_target      (resolve_target),
    .upd                 (upd_if.ctrl),
    .mispredict          (mispredict)
  );

endmodule

`default_nettype wire

// File: verif/tb_branch_predictor.sv
// Self-checking testbench for the branch predictor, INDEX_BITS = 3.
// Vectors come from verif/bp_vectors.txt, so run from the project root.
// Inputs change on the falling edge, outputs are sampled 10 ns before
// the next rising edge. Stops at the first mismatch.

`timescale 1ns/100ps
`default_nettype none

module tb_branch_predictor;

  localparam int CLK_PERIOD = 100;                     // ns
  localparam int SAMPLE_DLY = CLK_PERIOD / 2 - 10;     // From falling edge to sample point

  // One vector line, in file column order, all hex
  typedef struct packed {
    logic               lookup_en;
    bp_pkg::pc_t        fetch_pc;
    logic               resolve_valid;
    bp_pkg::pc_t        resolve_pc;
    bp_pkg::ctr_state_e resolve_pred_state;
    bp_pkg::pc_t        resolve_pred_target;
    logic               resolve_taken;
    bp_pkg::pc_t        resolve_target;
    logic               exp_taken;       // Expected pred_taken
    bp_pkg::ctr_state_e exp_state;       // Expected pred_state
    bp_pkg::pc_t        exp_target;      // Expected pred_target
    logic               exp_mispredict;  // Expected mispredict
  } vector_t;

  vector_t vectors[$];

  logic               clk;
  logic               rst;
  logic               lookup_en;
  bp_pkg::pc_t        fetch_pc;
  logic               resolve_valid;
  bp_pkg::pc_t        resolve_pc;
  bp_pkg::ctr_state_e resolve_pred_state;
  bp_pkg::pc_t        resolve_pred_target;
  logic               resolve_taken;
  bp_pkg::pc_t        resolve_target;
  logic               pred_taken;
  bp_pkg::ctr_state_e pred_state;
  bp_pkg::pc_t        pred_target;
  logic               mispredict;

  int cycle_count = 0;  // Rising edges seen
  int cycle_limit = 0;  // Set once the vectors are loaded

  branch_predictor #(.INDEX_BITS(3)) dut_i (
    .clk                 (clk),
    .rst                 (rst),
    .lookup_en           (lookup_en),
    .fetch_pc            (fetch_pc),
    .pred_taken          (pred_taken),
    .pred_state          (pred_state),
    .pred_target         (pred_target),
    .resolve_valid       (resolve_valid),
    .resolve_pc          (resolve_pc),
    .resolve_pred_state  (resolve_pred_state),
    .resolve_pred_target (resolve_pred_target),
    .resolve_taken       (resolve_taken),
    .resolve_target      (resolve_target),
    .mispredict          (mispredict)
  );

  ////////////////////////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////////////////////////
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("ERROR: run did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_state(input string name, input bp_pkg::ctr_state_e exp,
                             input bp_pkg::ctr_state_e act);
    if (act !== exp) begin
      $display("FAILED time=%0t signal=%s expected=%s actual=%s",
               $time, name, exp.name(), act.name());
      abort_run();
    end
  endtask

  task automatic check_pc(input string name, input bp_pkg::pc_t exp, input bp_pkg::pc_t act);
    if (act !== exp) begin
      $display("FAILED time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      abort_run();
    end
  endtask

  // Whole file is read up front so the cycle limit is known before the run
  task automatic load_vectors();
    int          fd;
    int          code;
    logic        le, rv, rt, et, em;
    bp_pkg::pc_t fpc, rpc, rpt, rtgt, etgt;
    logic [1:0]  rps, est;
    vector_t     v;
    fd = $fopen("verif/bp_vectors.txt", "r");
    if (fd == 0) begin
      $display("ERROR: vector file verif/bp_vectors.txt could not be opened");
      abort_run();
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h\n",
                       le, fpc, rv, rpc, rps, rpt, rt, rtgt, et, est, etgt, em);
        if (code == 12) begin
          v.lookup_en           = le;
          v.fetch_pc            = fpc;
          v.resolve_valid       = rv;
          v.resolve_pc          = rpc;
          v.resolve_pred_state  = bp_pkg::ctr_state_e'(rps);
          v.resolve_pred_target = rpt;
          v.resolve_taken       = rt;
          v.resolve_target      = rtgt;
          v.exp_taken           = et;
          v.exp_state           = bp_pkg::ctr_state_e'(est);
          v.exp_target          = etgt;
          v.exp_mispredict      = em;
          vectors.push_back(v);
        end else if (code > 0) begin
          $display("ERROR: vector line %0d is incomplete", vectors.size() + 1);
          abort_run();
        end else begin
          break;  // End of file or trailing blank
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_inputs(input vector_t v);
    lookup_en           = v.lookup_en;
    fetch_pc            = v.fetch_pc;
    resolve_valid       = v.resolve_valid;
    resolve_pc          = v.resolve_pc;
    resolve_pred_state  = v.resolve_pred_state;
    resolve_pred_target = v.resolve_pred_target;
    resolve_taken       = v.resolve_taken;
    resolve_target      = v.resolve_target;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    rst                 = 1'b1;
    lookup_en           = 1'b0;
    fetch_pc            = '0;
    resolve_valid       = 1'b0;
    resolve_pc          = '0;
    resolve_pred_state  = bp_pkg::strong_nt;
    resolve_pred_target = '0;
    resolve_taken       = 1'b0;
    resolve_target      = '0;

    load_vectors();
    if (vectors.size() == 0) begin
      $display("ERROR: vector file holds no vectors");
      abort_run();
    end
    cycle_limit = 2 * vectors.size() + 20;

    repeat (2) @(posedge clk);  // Two reset cycles
    @(negedge clk);
    rst = 1'b0;

    foreach (vectors[i]) begin
      drive_inputs(vectors[i]);
      #(SAMPLE_DLY);            // Combinational outputs settled
      check_bit("pred_taken", vectors[i].exp_taken, pred_taken);
      check_state("pred_state", vectors[i].exp_state, pred_state);
      check_pc("pred_target", vectors[i].exp_target, pred_target);
      check_bit("mispredict", vectors[i].exp_mispredict, mispredict);
      @(negedge clk);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: branch_predictor.f
src/bp_pkg.sv
src/bp_if.sv
src/bht.sv
src/btb.sv
src/bp_resolve.sv
src/branch_predictor.sv
verif/tb_branch_predictor.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator.
# Run from anywhere; all paths are relative to the project root.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
TOP=tb_branch_predictor

verilator --binary --timing \
  --top-module "$TOP" \
  -f branch_predictor.f \
  --Mdir obj_dir -o "$TOP" > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/"$TOP" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^RESULT: PASS$" "$SIM_LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Pass message not found in $SIM_LOG"
  exit 1
fi

// File: verif/bp_vectors.txt
1 0100 0 0000 0 0000 0 0000 0 0 0102 0
1 0abe 0 0000 0 0000 0 0000 0 0 0ac0 0
1 fffe 0 0000 0 0000 0 0000 0 0 0000 0
1 0104 1 0104 0 0106 1 0200 0 0 0106 1
1 0104 1 0104 1 0200 1 0200 0 1 0200 1
1 0104 1 0104 2 0200 1 0200 1 2 0200 0
1 0104 1 0104 3 0200 1 0200 1 3 0200 0
1 0104 1 0104 3 0200 0 0106 1 3 0200 1
1 0104 1 0104 2 0200 0 0106 1 2 0200 1
1 0104 1 0104 1 0200 0 0106 0 1 0200 0
1 0104 1 0104 0 0200 0 0106 0 0 0200 0
1 0104 0 0000 0 0000 0 0000 0 0 0200 0
1 0010 1 0010 0 0012 1 0400 0 0 0012 1
1 0010 1 0010 1 0400 1 0500 0 1 0400 1
1 0010 1 0010 2 0500 1 0600 1 2 0500 1
1 0010 0 0000 0 0000 0 0000 1 3 0600 0
1 0104 1 0204 0 0206 1 0300 0 0 0200 1
1 0104 0 0000 0 0000 0 0000 0 0 0106 0
1 0204 0 0000 0 0000 0 0000 0 1 0300 0
0 0010 0 0000 0 0000 0 0000 0 0 0012 0
0 0204 1 0010 3 0600 1 0600 0 0 0206 0
1 0010 0 0000 0 0000 0 0000 1 3 0600 0
1 0204 0 0000 0 0000 0 0000 0 1 0300 0
0 0000 0 0010 0 0000 1 0700 0 0 0002 0
1 0010 0 0000 0 0000 0 0000 1 3 0600 0
